// File: common/aluPkg.sv
package aluPkg;

	// --------------------------------------------------
	// datapath widths
	// --------------------------------------------------
	localparam int DATA_WIDTH = 16;
	localparam int IMM_WIDTH = 8;
	localparam int SHIFT_WIDTH = 4;

	// top five bits of every instruction word
	// 10111 through 11111 are unused and come out as illegal
	typedef enum logic [4:0] {
		ADD = 5'b00000,
		ADDI = 5'b00001,
		ADDU = 5'b00010,
		ADDUI = 5'b00011,
		ADDC = 5'b00100,
		ADDCU = 5'b00101,
		ADDCUI = 5'b00110,
		ADDCI = 5'b00111,
		SUB = 5'b01000,
		SUBI = 5'b01001,
		CMP = 5'b01010,
		CMPI = 5'b01011,
		CMPUI = 5'b01100,
		AND = 5'b01101,
		OR = 5'b01110,
		XOR = 5'b01111,
		NOT = 5'b10000,
		LSH = 5'b10001,
		LSHI = 5'b10010,
		RSH = 5'b10011,
		RSHI = 5'b10100,
		ALSH = 5'b10101,
		ARSH = 5'b10110
	} opCodeT;

	// --------------------------------------------------
	// instruction word, two views of the same 16 bits
	// --------------------------------------------------
	typedef struct packed {
		opCodeT opCode;
		logic [2:0] rdestIdx;
		logic [SHIFT_WIDTH-1:0] shiftAmount;
		// read port index, used by the register file outside
		logic [3:0] rsrcIdx;
	} aluRegFormT;

	typedef struct packed {
		opCodeT opCode;
		logic [2:0] rdestIdx;
		logic [IMM_WIDTH-1:0] imm;
	} aluImmFormT;

	// opcode picks the view, same position in both
	typedef union packed {
		aluRegFormT regForm;
		aluImmFormT immForm;
	} aluWordT;

	// processor status bits, carry at bit 0 and negative at bit 4
	typedef struct packed {
		logic negative;
		logic zero;
		logic overflow;
		logic low;
		logic carry;
	} flagsT;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] value;
		// unit decoded this opcode
		logic hit;
	} unitResultT;

	typedef struct packed {
		unitResultT unit;
		flagsT flags;
		// low for compares
		logic writes;
	} arithResultT;

	// --------------------------------------------------
	// opcode classes
	// --------------------------------------------------
	function automatic logic isImmediate(input opCodeT op);
		return op inside {ADDI, ADDUI, ADDCI, ADDCUI, SUBI, CMPI, CMPUI, LSHI, RSHI};
	endfunction

	// sign-extended immediates, the rest are zero-extended
	function automatic logic isSignedImm(input opCodeT op);
		return op inside {ADDI, ADDCI, SUBI, CMPI};
	endfunction

endpackage

// File: arith/arithUnit.sv
module arithUnit (
	input aluPkg::aluWordT instr,
	input logic [aluPkg::DATA_WIDTH-1:0] rsrcValue,
	input logic [aluPkg::DATA_WIDTH-1:0] rdestValue,
	input aluPkg::flagsT flags,
	output aluPkg::arithResultT arithOut
);
	import aluPkg::*;

	opCodeT opCode;
	logic [IMM_WIDTH-1:0] imm;
	logic [DATA_WIDTH-1:0] immExt;
	logic [DATA_WIDTH-1:0] operand;
	logic [DATA_WIDTH-1:0] addend;
	logic [DATA_WIDTH-1:0] sum;
	logic carryOut;
	logic carryIn;
	logic hit;
	logic isSub;
	logic useCarry;
	logic writes;

	// opcode sits in the same place in both views
	assign opCode = instr.regForm.opCode;
	assign imm = instr.immForm.imm;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	always_comb begin
		hit = 1'b1;
		isSub = 1'b0;
		useCarry = 1'b0;
		writes = 1'b1;
		case (opCode)
			ADD, ADDI, ADDU, ADDUI: begin
				isSub = 1'b0;
			end
			// carry comes from the status register
			ADDC, ADDCU, ADDCUI, ADDCI: begin
				useCarry = 1'b1;
			end
			SUB, SUBI: begin
				isSub = 1'b1;
			end
			// same subtract, nothing written back
			CMP, CMPI, CMPUI: begin
				isSub = 1'b1;
				writes = 1'b0;
			end
			default: begin
				hit = 1'b0;
				writes = 1'b0;
			end
		endcase
	end

	// --------------------------------------------------
	// second operand
	// --------------------------------------------------
	// 8-bit immediate widened to the datapath
	assign immExt = isSignedImm(opCode) ? {{(DATA_WIDTH - IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm}
	                                    : {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, imm};

	assign operand = isImmediate(opCode) ? immExt : rsrcValue;

	// --------------------------------------------------
	// adder
	// --------------------------------------------------
	// subtract is rdest + ~operand + 1
	assign addend = isSub ? ~operand : operand;
	assign carryIn = isSub ? 1'b1 : (useCarry & flags.carry);

	assign {carryOut, sum} = {1'b0, rdestValue} + {1'b0, addend}
	                         + {{DATA_WIDTH{1'b0}}, carryIn};

	// --------------------------------------------------
	// flags
	// --------------------------------------------------
	// carry out, borrow inverted on subtract
	assign arithOut.flags.carry = carryOut;

	// unsigned rdest below operand
	assign arithOut.flags.low = rdestValue < operand;

	// inputs agree in sign but the sum does not
	// addend is already inverted for subtract, so one rule covers both
	assign arithOut.flags.overflow = (rdestValue[DATA_WIDTH-1] == addend[DATA_WIDTH-1])
	                                 && (sum[DATA_WIDTH-1] != rdestValue[DATA_WIDTH-1]);

	assign arithOut.flags.zero = sum == '0;

	// signed rdest below operand
	assign arithOut.flags.negative = $signed(rdestValue) < $signed(operand);

	assign arithOut.unit.value = sum;
	assign arithOut.unit.hit = hit;
	assign arithOut.writes = writes;

endmodule

// File: rtl/logicShiftUnit.sv
module logicShiftUnit (
	input aluPkg::aluWordT instr,
	input logic [aluPkg::DATA_WIDTH-1:0] rsrcValue,
	input logic [aluPkg::DATA_WIDTH-1:0] rdestValue,
	output aluPkg::unitResultT logicOut
);
	import aluPkg::*;

	opCodeT opCode;
	logic [SHIFT_WIDTH-1:0] amount;

	assign opCode = instr.regForm.opCode;

	// --------------------------------------------------
	// shift amount
	// --------------------------------------------------
	// immediate shifts use the low four bits of imm
	// register shifts use the shiftAmount field
	assign amount = isImmediate(opCode) ? instr.immForm.imm[SHIFT_WIDTH-1:0]
	                                    : instr.regForm.shiftAmount;

	// --------------------------------------------------
	// logic and shift select
	// --------------------------------------------------
	always_comb begin
		logicOut.hit = 1'b1;
		case (opCode)
			AND: begin
				logicOut.value = rsrcValue & rdestValue;
			end
			OR: begin
				logicOut.value = rsrcValue | rdestValue;
			end
			XOR: begin
				logicOut.value = rsrcValue ^ rdestValue;
			end
			// bitwise complement of rsrc
			NOT: begin
				logicOut.value = ~rsrcValue;
			end
			// left shifts fill zeros, arithmetic or not
			LSH, LSHI, ALSH: begin
				logicOut.value = rsrcValue << amount;
			end
			RSH, RSHI: begin
				logicOut.value = rsrcValue >> amount;
			end
			// sign bit copied in from the top
			ARSH: begin
				logicOut.value = $signed(rsrcValue) >>> amount;
			end
			// not ours, arith unit or illegal
			default: begin
				logicOut.value = '0;
				logicOut.hit = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/writebackMerge.sv
module writebackMerge (
	input logic clk,
	input logic reset,
	input logic inValid,
	input aluPkg::aluWordT instr,
	input aluPkg::arithResultT arithOut,
	input aluPkg::unitResultT logicOut,
	output logic outValid,
	output logic writeEnable,
	output logic [2:0] writeIdx,
	output logic [aluPkg::DATA_WIDTH-1:0] result,
	output logic illegal,
	output aluPkg::flagsT flags
);
	import aluPkg::*;

	logic anyHit;
	logic nextWrite;
	logic [DATA_WIDTH-1:0] nextResult;

	// units decode disjoint sets, at most one hit
	assign anyHit = arithOut.unit.hit | logicOut.hit;

	// --------------------------------------------------
	// result select
	// --------------------------------------------------
	always_comb begin
		if (arithOut.unit.hit) begin
			nextResult = arithOut.unit.value;
			nextWrite = arithOut.writes;
		end else if (logicOut.hit) begin
			nextResult = logicOut.value;
			nextWrite = 1'b1;
		end else begin
			// illegal opcode gives zero
			nextResult = '0;
			nextWrite = 1'b0;
		end
	end

	// --------------------------------------------------
	// control and status register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			writeEnable <= 1'b0;
			illegal <= 1'b0;
			flags <= '0;
		end else begin
			// one cycle behind the strobe
			outValid <= inValid;
			writeEnable <= inValid & nextWrite;
			illegal <= inValid & ~anyHit;
			// only arithmetic ops touch the flags
			if (inValid && arithOut.unit.hit) begin
				flags <= arithOut.flags;
			end
		end
	end

	// result and destination index
	always_ff @(posedge clk) begin
		if (inValid) begin
			result <= nextResult;
			writeIdx <= instr.regForm.rdestIdx;
		end
	end

endmodule

// File: rtl/executeTop.sv
module executeTop (
	input logic clk,
	input logic reset,
	input logic inValid,
	input aluPkg::aluWordT instr,
	input logic [aluPkg::DATA_WIDTH-1:0] rsrcValue,
	input logic [aluPkg::DATA_WIDTH-1:0] rdestValue,
	output logic outValid,
	output logic writeEnable,
	output logic [2:0] writeIdx,
	output logic [aluPkg::DATA_WIDTH-1:0] result,
	output aluPkg::flagsT flags,
	output logic illegal
);
	import aluPkg::*;

	arithResultT arithOut;
	unitResultT logicOut;

	// --------------------------------------------------
	// combinational units
	// --------------------------------------------------
	// status register carry feeds back for the add-with-carry ops
	arithUnit arith0 (
		.instr(instr),
		.rsrcValue(rsrcValue),
		.rdestValue(rdestValue),
		.flags(flags),
		.arithOut(arithOut)
	);

	logicShiftUnit logic0 (
		.instr(instr),
		.rsrcValue(rsrcValue),
		.rdestValue(rdestValue),
		.logicOut(logicOut)
	);

	// registered writeback and flags
	writebackMerge merge0 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.instr(instr),
		.arithOut(arithOut),
		.logicOut(logicOut),
		.outValid(outValid),
		.writeEnable(writeEnable),
		.writeIdx(writeIdx),
		.result(result),
		.illegal(illegal),
		.flags(flags)
	);

endmodule

// File: dv/executeChecker.sv
module executeChecker (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input aluPkg::arithResultT arithOut,
	input aluPkg::flagsT flags
);
	timeunit 1ns;
	timeprecision 100ps;

	int strobeFails = 0;
	int idleFails = 0;
	int resetFails = 0;
	int flagFails = 0;
	int failCount;

	assign failCount = strobeFails + idleFails + resetFails + flagFails;

	// --------------------------------------------------
	// strobe timing
	// --------------------------------------------------
	strobeFollows: assert property (@(posedge clk) disable iff (reset) inValid |=> outValid)
		else begin
			strobeFails = strobeFails + 1;
			$error("outValid stayed low one cycle after inValid");
		end

	idleQuiet: assert property (@(posedge clk) disable iff (reset) !inValid |=> !outValid)
		else begin
			idleFails = idleFails + 1;
			$error("outValid rose without a strobe the cycle before");
		end

	resetQuiet: assert property (@(posedge clk) reset |=> !outValid)
		else begin
			resetFails = resetFails + 1;
			$error("outValid high after a reset cycle");
		end

	// status register moves only on an arithmetic strobe
	flagsHold: assert property (@(posedge clk) disable iff (reset)
	                            !(inValid && arithOut.unit.hit) |=> $stable(flags))
		else begin
			flagFails = flagFails + 1;
			$error("flags changed without an arithmetic strobe");
		end

endmodule

bind writebackMerge executeChecker checker0 (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.outValid(outValid),
	.arithOut(arithOut),
	.flags(flags)
);

// File: dv/resultMonitor.sv
module resultMonitor (
	input logic clk,
	input logic reset,
	input logic outValid,
	input logic writeEnable,
	input logic [2:0] writeIdx,
	input logic [aluPkg::DATA_WIDTH-1:0] result,
	input aluPkg::flagsT flags,
	input logic illegal,
	input logic expValid,
	input int expStep,
	input aluPkg::opCodeT expOp,
	input logic [2:0] expIdx,
	input logic [aluPkg::DATA_WIDTH-1:0] expResult,
	input logic expWe,
	input logic expIll,
	input aluPkg::flagsT expFlags,
	output int errorCount
);
	timeunit 1ns;
	timeprecision 100ps;

	import aluPkg::*;

	int errs = 0;

	// expected values, one cycle behind the strobe
	logic pendValid = 1'b0;
	int pendStep;
	opCodeT pendOp;
	logic [2:0] pendIdx;
	logic [DATA_WIDTH-1:0] pendResult;
	logic pendWe;
	logic pendIll;
	flagsT pendFlags;

	assign errorCount = errs;

	function automatic string describeStep(input int step, input opCodeT op);
		string opName;
		opName = op.name();
		// unused encodings have no enum name
		if (opName == "") begin
			opName = "ILLEGAL";
		end
		return $sformatf("step%0d_%s", step, opName);
	endfunction

	task automatic compareField(input string name, input string field,
	                            input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %h actual %h", name, field, expected, actual);
			errs = errs + 1;
		end
	endtask

	always @(posedge clk) begin
		pendValid <= reset ? 1'b0 : expValid;
		pendStep <= expStep;
		pendOp <= expOp;
		pendIdx <= expIdx;
		pendResult <= expResult;
		pendWe <= expWe;
		pendIll <= expIll;
		pendFlags <= expFlags;
	end

	// --------------------------------------------------
	// compare at the falling edge, outputs are settled
	// --------------------------------------------------
	always @(negedge clk) begin
		string name;
		if (pendValid) begin
			name = describeStep(pendStep, pendOp);
		end else begin
			name = "idle";
		end
		// low in reset and idle cycles, high right after a strobe
		compareField(name, "outValid", {15'b0, pendValid}, {15'b0, outValid});
		if (pendValid) begin
			compareField(name, "writeEnable", {15'b0, pendWe}, {15'b0, writeEnable});
			compareField(name, "illegal", {15'b0, pendIll}, {15'b0, illegal});
			compareField(name, "writeIdx", {13'b0, pendIdx}, {13'b0, writeIdx});
			compareField(name, "flags", {11'b0, pendFlags}, {11'b0, flags});
			// compares write nothing back, result not checked there
			if (pendWe || pendIll) begin
				compareField(name, "result", pendResult, result);
			end
		end
	end

endmodule

// File: dv/executeTb.sv
module executeTb;
	timeunit 1ns;
	timeprecision 100ps;

	import aluPkg::*;

	localparam int MAX_STEPS = 64;
	localparam int RESET_CYCLES = 8;

	// one line of the stimulus file holds 80 bits
	typedef struct packed {
		aluWordT word;
		logic [DATA_WIDTH-1:0] rsrcValue;
		logic [DATA_WIDTH-1:0] rdestValue;
		logic [DATA_WIDTH-1:0] result;
		logic [3:0] writeEnable;
		logic [3:0] illegal;
		logic [2:0] spare;
		flagsT flags;
	} stimRecT;

	logic [79:0] stimMem [0:MAX_STEPS-1];

	// DUT inputs
	logic clk = 1'b0;
	logic reset;
	logic inValid;
	aluWordT instr;
	logic [DATA_WIDTH-1:0] rsrcValue;
	logic [DATA_WIDTH-1:0] rdestValue;

	// DUT outputs
	logic outValid;
	logic writeEnable;
	logic [2:0] writeIdx;
	logic [DATA_WIDTH-1:0] result;
	flagsT flags;
	logic illegal;

	// expected record handed to the monitor
	logic expValid;
	int expStep;
	opCodeT expOp;
	logic [2:0] expIdx;
	logic [DATA_WIDTH-1:0] expResult;
	logic expWe;
	logic expIll;
	flagsT expFlags;

	int monitorErrors;
	int checkerErrors;
	int setupErrors = 0;
	int nSteps = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	executeTop dut0 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.instr(instr),
		.rsrcValue(rsrcValue),
		.rdestValue(rdestValue),
		.outValid(outValid),
		.writeEnable(writeEnable),
		.writeIdx(writeIdx),
		.result(result),
		.flags(flags),
		.illegal(illegal)
	);

	resultMonitor monitor0 (
		.clk(clk),
		.reset(reset),
		.outValid(outValid),
		.writeEnable(writeEnable),
		.writeIdx(writeIdx),
		.result(result),
		.flags(flags),
		.illegal(illegal),
		.expValid(expValid),
		.expStep(expStep),
		.expOp(expOp),
		.expIdx(expIdx),
		.expResult(expResult),
		.expWe(expWe),
		.expIll(expIll),
		.expFlags(expFlags),
		.errorCount(monitorErrors)
	);

	// assertion failures from the bound checker
	assign checkerErrors = dut0.merge0.checker0.failCount;

	// 100 ns period
	always #50 clk = ~clk;

	// --------------------------------------------------
	// timeout
	// --------------------------------------------------
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the run did not finish", cycleCount);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic driveStep(input stimRecT rec, input int step);
		inValid = 1'b1;
		instr = rec.word;
		rsrcValue = rec.rsrcValue;
		rdestValue = rec.rdestValue;
		expValid = 1'b1;
		expStep = step;
		expOp = rec.word.regForm.opCode;
		expIdx = rec.word.regForm.rdestIdx;
		expResult = rec.result;
		expWe = rec.writeEnable[0];
		expIll = rec.illegal[0];
		expFlags = rec.flags;
	endtask

	task automatic driveIdle();
		inValid = 1'b0;
		expValid = 1'b0;
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		int totalErrors;
		reset = 1'b1;
		// a strobe during reset must not reach outValid
		inValid = 1'b1;
		instr = '0;
		rsrcValue = '0;
		rdestValue = '0;
		expValid = 1'b0;
		expStep = 0;
		expOp = ADD;
		expIdx = '0;
		expResult = '0;
		expWe = 1'b0;
		expIll = 1'b0;
		expFlags = '0;

		$readmemh("dv/executeStim.txt", stimMem);
		// record 0 carries the operation count
		nSteps = int'(stimMem[0][7:0]);
		if (nSteps < 1 || nSteps > MAX_STEPS - 1) begin
			$display("stimulus file holds %0d operations, which cannot be run", nSteps);
			setupErrors = setupErrors + 1;
			nSteps = 0;
		end
		cycleLimit = RESET_CYCLES + 2 * nSteps + 20;

		repeat (RESET_CYCLES - 2) @(posedge clk);
		#1;
		inValid = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 1; i <= nSteps; i++) begin
			@(posedge clk);
			#1;
			driveStep(stimMem[i], i);
			// a gap after every fourth op and the rest back to back
			if (i % 4 == 0) begin
				@(posedge clk);
				#1;
				driveIdle();
			end
		end
		@(posedge clk);
		#1;
		driveIdle();
		// let the last compare happen
		repeat (2) @(posedge clk);

		totalErrors = monitorErrors + checkerErrors + setupErrors;
		$display("errors: monitor %0d, assertions %0d, setup %0d, total %0d",
		         monitorErrors, checkerErrors, setupErrors, totalErrors);
		if (totalErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: dv/executeStim.txt
// columns: word_rsrc_rdest_result_writeEnable_illegal_flags, all hex, flags = {3'b0,N,Z,F,L,C}
// record 0 holds the number of operations in its low byte
0000_0000_0000_0000_0_0_1d // operation count
0102_0f0f_1234_2143_1_0_00 // ADD no carry
0203_8000_8000_0000_1_0_0d // ADD carry, overflow, zero
2304_0002_0001_0004_1_0_12 // ADDC with carry in
2405_0001_00ff_0100_1_0_00 // ADDC without carry in
1506_0003_ffff_0002_1_0_11 // ADDU carry out
2e07_0000_7fff_8000_1_0_04 // ADDCU carry in, overflow
0efe_aaaa_0005_0003_1_0_03 // ADDI imm -2
3f80_5555_0100_0081_1_0_03 // ADDCI imm -128 with carry
19f0_1234_0010_0100_1_0_12 // ADDUI imm zero-extended
32ff_0000_ff01_0000_1_0_19 // ADDCUI no carry in, zero
4103_0030_0050_0020_1_0_01 // SUB
4204_0020_0010_fff0_1_0_12 // SUB borrow
4b01_0000_8000_7fff_1_0_15 // SUBI overflow
5405_1234_1234_0000_0_0_09 // CMP equal
5d05_0000_ffff_fffa_0_0_11 // CMPI signed less
6680_0000_0003_ff83_0_0_12 // CMPUI unsigned less
6f01_f0f0_ff00_f000_1_0_12 // AND
7002_00f0_0f00_0ff0_1_0_12 // OR
7903_aaaa_ffff_5555_1_0_12 // XOR
8204_00ff_1234_ff00_1_0_12 // NOT
8b45_1234_0000_2340_1_0_12 // LSH by 4
94f3_0011_0000_0088_1_0_12 // LSHI by 3
9d81_8400_0000_0084_1_0_12 // RSH by 8
a602_f000_0000_3c00_1_0_12 // RSHI by 2
af12_8001_0000_0002_1_0_12 // ALSH by 1
b141_8420_0000_f842_1_0_12 // ARSH by 4
ba00_0001_0001_0000_0_1_12 // unused opcode 17
ffff_0001_0001_0000_0_1_12 // unused opcode 1f
0001_ffff_0001_0000_1_0_0b // ADD after illegal

// File: sources.f
common/aluPkg.sv
arith/arithUnit.sv
rtl/logicShiftUnit.sv
rtl/writebackMerge.sv
rtl/executeTop.sv
dv/executeChecker.sv
dv/resultMonitor.sv
dv/executeTb.sv

// File: Makefile
VERILATOR = verilator
TOP = executeTb
FILELIST = sources.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Regression failed
COMMON_FLAGS = --timing --assert --timescale 1ns/100ps --top-module $(TOP)
LINT_FLAGS = --lint-only $(COMMON_FLAGS)
SIM_FLAGS = --binary -j 0 $(COMMON_FLAGS) --Mdir $(BUILD_DIR)
SIM_ARGS = +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
